//--- compile.f
+incdir+rtl
rtl/vector_lane_pkg.sv
rtl/arithmetic_unit.sv
rtl/multiply_unit.sv
rtl/lane_writeback.sv
rtl/vector_lane.sv
verif/vector_lane_sva.sv
verif/tb_vector_lane.sv

//--- Makefile
# Verilator build and run for the vector lane testbench

VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_vector_lane
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_TEXT = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation output is shown, then searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/vector_lane_trace.txt
// per op: header (chain flag, selector 0 idle 1 arith 2 mul, opcode) src_a src_b expected
// chain 1 issues with no random idle gap in front, the tag is the op's line number from 0
010 00000005 00000003 00000008
110 7fffffff 00000001 80000000
111 00000003 00000005 fffffffe
012 f0f0ff00 3c3c0ff0 30300f00
113 f0f0ff00 3c3c0ff0 fcfcfff0
114 f0f0ff00 3c3c0ff0 ccccf0f0
015 00000001 00000024 00000010
016 80000000 00000004 08000000
117 80000000 00000004 f8000000
017 fffffff0 00000002 fffffffc
018 fffffffb 00000003 fffffffb
119 fffffffb 00000003 00000003
018 80000000 7fffffff 80000000
119 80000000 7fffffff 7fffffff
020 00000007 00000006 0000002a
120 fffffffd 00000005 fffffff1
121 fffffffd 00000005 ffffffff
122 fffffffd 00000005 00000004
122 ffffffff ffffffff fffffffe
021 ffffffff ffffffff 00000000
021 80000000 80000000 40000000
021 7fffffff 80000000 c0000000
020 12345678 00000010 23456780
020 00000003 00000004 0000000c
100 00000000 00000000 00000000
110 00000010 00000020 00000030
020 00000002 00000009 00000012
111 00000064 00000001 00000063
114 0000ffff 00ff00ff 00ffff00
019 00000010 ffffffff 00000010

//--- verif/tb_vector_lane.sv
// testbench for one vector lane
// replays verif/vector_lane_trace.txt, four hex words per op, a header with chain
// flag, selector and opcode, then src_a, src_b and the expected result
// each op is tagged with its line number, expected results are kept per tag
// stall and result timing come from a small model of the lane issue rules
// run from the project root so the trace path resolves

`timescale 1ns/1ps

module tb_vector_lane;

  localparam int TRACE_LINES  = 30;
  localparam int MAX_GAP      = 3;  // longest idle gap before an unchained op
  localparam int DRAIN        = 6;  // quiet cycles at the end, catches stray results
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = 4 * TRACE_LINES + MAX_GAP * TRACE_LINES + 50;

  logic                      CLK;
  logic                      reset;
  vector_lane_pkg::fu_type_e fu_type;
  vector_lane_pkg::op_t      op;
  vector_lane_pkg::word_t    src_a;
  vector_lane_pkg::word_t    src_b;
  vector_lane_pkg::tag_t     tag;
  logic                      stall;
  vector_lane_pkg::word_t    result;
  vector_lane_pkg::tag_t     result_tag;
  logic                      result_valid;

  logic [31:0]            trace_words [0:4*TRACE_LINES-1];
  vector_lane_pkg::word_t exp_result [0:TRACE_LINES-1]; // indexed by tag
  logic                   returned [0:TRACE_LINES-1];
  logic                   due_valid [0:3];              // result slots by cycle mod 4
  vector_lane_pkg::tag_t  due_tag [0:3];
  logic                   mul_prev1;                    // mul accepted last cycle
  logic                   mul_prev2;                    // two cycles back
  logic                   from_trace;                   // this cycle drives a trace line
  logic                   saw_three_mul;
  integer                 seed;
  int                     cycle_count;
  int                     line_idx;
  int                     gap_left;
  int                     ops_expected;
  int                     results_seen;
  int                     stall_cycles;

  vector_lane dut_i (
    .CLK          (CLK),
    .reset        (reset),
    .fu_type      (fu_type),
    .op           (op),
    .src_a        (src_a),
    .src_b        (src_b),
    .tag          (tag),
    .stall        (stall),
    .result       (result),
    .result_tag   (result_tag),
    .result_valid (result_valid)
  );

  always #5 CLK = ~CLK; // 10 ns period

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "vector lane test stopped");
  endtask

  task automatic compare_word(input string name, input vector_lane_pkg::word_t actual,
                              input vector_lane_pkg::word_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0t: %s is 0x%08h, expected 0x%08h",
                                  $time, name, actual, expected));
    end
  endtask

  task automatic verify_tag(input string name, input vector_lane_pkg::tag_t actual,
                            input vector_lane_pkg::tag_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0t: %s is %0d, expected %0d",
                                  $time, name, actual, expected));
    end
  endtask

  task automatic expect_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("** Error at %0t: %s is %b, expected %b",
                                  $time, name, actual, expected));
    end
  endtask

  // zero most of the time, otherwise 1 to MAX_GAP idle cycles
  function automatic int pick_gap();
    int r;
    r = $random(seed);
    if ((r & 4) != 0) begin
      pick_gap = (r & 3) % MAX_GAP + 1;
    end else begin
      pick_gap = 0;
    end
  endfunction

  task automatic drive_idle();
    fu_type = vector_lane_pkg::FU_NONE;
    op      = '0;
    src_a   = '0;
    src_b   = '0;
    tag     = '0;
  endtask

  // a stalled line is simply driven again, so the op holds
  task automatic issue_from_trace();
    logic [31:0] hdr;
    from_trace = 1'b0;
    if (gap_left > 0) begin
      drive_idle();
      gap_left--;
    end else if (line_idx < TRACE_LINES) begin
      hdr        = trace_words[4*line_idx];
      fu_type    = vector_lane_pkg::fu_type_e'(hdr[5:4]);
      op         = hdr[3:0];
      src_a      = trace_words[4*line_idx+1];
      src_b      = trace_words[4*line_idx+2];
      tag        = vector_lane_pkg::tag_t'(line_idx); // line number is the tag
      from_trace = 1'b1;
    end else begin
      drive_idle();
    end
  endtask

  // stall rule, then schedule the result 1 or 3 cycles out
  task automatic predict_issue();
    logic exp_stall;
    logic acc_arith;
    logic acc_mul;
    exp_stall = fu_type == vector_lane_pkg::FU_ARITH && mul_prev2;
    expect_bit("stall", stall, exp_stall);
    acc_arith = fu_type == vector_lane_pkg::FU_ARITH && !exp_stall;
    acc_mul   = fu_type == vector_lane_pkg::FU_MUL; // never held back
    if (exp_stall) begin
      stall_cycles++;
    end
    if (acc_arith) begin
      due_valid[(cycle_count + 1) % 4] = 1'b1;
      due_tag[(cycle_count + 1) % 4]   = tag;
    end
    if (acc_mul) begin
      due_valid[(cycle_count + 3) % 4] = 1'b1;
      due_tag[(cycle_count + 3) % 4]   = tag;
    end
    if (acc_mul && mul_prev1 && mul_prev2) begin
      saw_three_mul = 1'b1; // three multiplies in the pipe
    end
    mul_prev2 = mul_prev1;
    mul_prev1 = acc_mul;
    if (from_trace && !exp_stall) begin
      line_idx++;
      if (line_idx < TRACE_LINES && trace_words[4*line_idx][8] == 1'b0) begin
        gap_left = pick_gap(); // unchained op may get idle cycles in front
      end
    end
  endtask

  // registered outputs of this cycle against the slot model
  task automatic collect_result();
    int slot;
    slot = cycle_count % 4;
    expect_bit("result_valid", result_valid, due_valid[slot]);
    if (due_valid[slot]) begin
      verify_tag("result_tag", result_tag, due_tag[slot]);
      compare_word("result", result, exp_result[due_tag[slot]]);
      if (returned[due_tag[slot]]) begin
        stop_with_failure($sformatf("tag %0d came back a second time", due_tag[slot]));
      end
      returned[due_tag[slot]] = 1'b1;
      results_seen++;
    end
    due_valid[slot] = 1'b0;
  endtask

  // one clock, entered and left at a falling edge
  task automatic run_cycle();
    collect_result();
    issue_from_trace();
    #1; // stall is combinational on the new fu_type
    predict_issue();
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d results back",
                                  cycle_count, results_seen, ops_expected));
    end
    @(negedge CLK);
  endtask

  initial begin
    CLK           = 1'b0;
    reset         = 1'b1;
    seed          = 32'h80b15c1f;
    cycle_count   = 0;
    line_idx      = 0;
    gap_left      = 0;
    ops_expected  = 0;
    results_seen  = 0;
    stall_cycles  = 0;
    mul_prev1     = 1'b0;
    mul_prev2     = 1'b0;
    from_trace    = 1'b0;
    saw_three_mul = 1'b0;
    drive_idle();
    for (int i = 0; i < 4; i++) begin
      due_valid[i] = 1'b0;
      due_tag[i]   = '0;
    end
    $readmemh("verif/vector_lane_trace.txt", trace_words);
    for (int i = 0; i < TRACE_LINES; i++) begin
      exp_result[i] = trace_words[4*i+3];
      returned[i]   = 1'b0;
      if (trace_words[4*i][5:4] != 2'd0) begin
        ops_expected++; // idle lines give no result
      end
    end
    if (trace_words[0][8] == 1'b0) begin
      gap_left = pick_gap();
    end
    repeat (RESET_CYCLES) @(negedge CLK);
    reset = 1'b0;
    // idle lane after reset stays quiet
    repeat (4) begin
      expect_bit("stall", stall, 1'b0);
      expect_bit("result_valid", result_valid, 1'b0);
      @(negedge CLK);
    end
    while (results_seen < ops_expected || line_idx < TRACE_LINES) begin
      run_cycle();
    end
    repeat (DRAIN) begin
      run_cycle();
    end
    if (results_seen == ops_expected && stall_cycles > 0 && saw_three_mul) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_failure($sformatf(
        "incomplete run with %0d of %0d results, %0d stall cycles, three in flight %0b",
        results_seen, ops_expected, stall_cycles, saw_three_mul));
    end
  end

endmodule

//--- verif/vector_lane_sva.sv
// assertions for the vector lane, bound into every vector_lane instance
// watches issue decode and the shared writeback slot from inside the lane
// covers stall, start strobes and result latency

`timescale 1ns/1ps

module vector_lane_sva (
  input logic                      CLK,
  input logic                      reset,
  input vector_lane_pkg::fu_type_e fu_type,
  input logic                      stall,
  input logic                      start_arith,
  input logic                      start_mul,
  input logic                      arith_done,
  input logic                      mul_done,
  input logic                      result_valid
);

  // only an arith op is ever held back, and only behind a multiply two cycles old
  stall_only_arith: assert property (@(posedge CLK) disable iff (reset)
    stall |-> fu_type == vector_lane_pkg::FU_ARITH && $past(start_mul, 2))
    else $error("stall high without an arith op behind a multiply");

  one_start: assert property (@(posedge CLK) disable iff (reset)
    !(start_arith && start_mul))
    else $error("both unit start strobes high");

  // the hazard stall keeps the writeback slot single
  one_done: assert property (@(posedge CLK) disable iff (reset)
    !(arith_done && mul_done))
    else $error("both units finished in the same cycle");

  arith_latency: assert property (@(posedge CLK) disable iff (reset)
    $past(start_arith) |-> result_valid)
    else $error("no result one cycle after an arith start");

  mul_latency: assert property (@(posedge CLK) disable iff (reset)
    $past(start_mul, 3) |-> result_valid)
    else $error("no result three cycles after a multiply start");

  // nothing shows up that was not issued
  no_stray_result: assert property (@(posedge CLK) disable iff (reset)
    result_valid |-> $past(start_arith) || $past(start_mul, 3))
    else $error("result_valid without a matching start");

endmodule

bind vector_lane vector_lane_sva sva_i (
  .CLK          (CLK),
  .reset        (reset),
  .fu_type      (fu_type),
  .stall        (stall),
  .start_arith  (start_arith),
  .start_mul    (start_mul),
  .arith_done   (arith_done),
  .mul_done     (mul_done),
  .result_valid (result_valid)
);

//--- rtl/vector_lane.sv
// top of one vector lane
// the environment presents one element op per cycle on fu_type, op,
// src_a, src_b and tag, and must hold it while stall is high
// arith results return one cycle after acceptance, multiplies three

`timescale 1ns/1ps

module vector_lane (
  input  logic                      CLK,
  input  logic                      reset,
  input  vector_lane_pkg::fu_type_e fu_type,
  input  vector_lane_pkg::op_t      op,
  input  vector_lane_pkg::word_t    src_a,
  input  vector_lane_pkg::word_t    src_b,
  input  vector_lane_pkg::tag_t     tag,
  output logic                      stall,
  output vector_lane_pkg::word_t    result,
  output vector_lane_pkg::tag_t     result_tag,
  output logic                      result_valid
);

  logic                   start_arith;
  logic                   start_mul;
  vector_lane_pkg::word_t arith_result;
  vector_lane_pkg::tag_t  arith_tag;
  logic                   arith_done;
  vector_lane_pkg::word_t mul_result;
  vector_lane_pkg::tag_t  mul_tag;
  logic                   mul_done;

  // operands, op and tag go to both units, the strobe picks the one that acts
  arithmetic_unit arith_i (
    .CLK        (CLK),
    .reset      (reset),
    .start      (start_arith),
    .op         (op),
    .src_a      (src_a),
    .src_b      (src_b),
    .tag        (tag),
    .result     (arith_result),
    .result_tag (arith_tag),
    .done       (arith_done)
  );

  multiply_unit mul_i (
    .CLK        (CLK),
    .reset      (reset),
    .start      (start_mul),
    .op         (op),
    .src_a      (src_a),
    .src_b      (src_b),
    .tag        (tag),
    .result     (mul_result),
    .result_tag (mul_tag),
    .done       (mul_done)
  );

  // decode, hazard stall and result merge
  lane_writeback wb_i (
    .CLK          (CLK),
    .reset        (reset),
    .fu_type      (fu_type),
    .start_arith  (start_arith),
    .start_mul    (start_mul),
    .stall        (stall),
    .arith_result (arith_result),
    .arith_tag    (arith_tag),
    .arith_done   (arith_done),
    .mul_result   (mul_result),
    .mul_tag      (mul_tag),
    .mul_done     (mul_done),
    .result       (result),
    .result_tag   (result_tag),
    .result_valid (result_valid)
  );

endmodule

//--- rtl/lane_writeback.sv
// issue decode and writeback for one vector lane
// turns fu_type into start strobes, holds back an arith op that would
// collide with a multiply finishing in the same cycle, then merges the
// two unit results into the single lane result port

`timescale 1ns/1ps

module lane_writeback (
  input  logic                      CLK,
  input  logic                      reset,
  input  vector_lane_pkg::fu_type_e fu_type,
  output logic                      start_arith,
  output logic                      start_mul,
  output logic                      stall,
  input  vector_lane_pkg::word_t    arith_result,
  input  vector_lane_pkg::tag_t     arith_tag,
  input  logic                      arith_done,
  input  vector_lane_pkg::word_t    mul_result,
  input  vector_lane_pkg::tag_t     mul_tag,
  input  logic                      mul_done,
  output vector_lane_pkg::word_t    result,
  output vector_lane_pkg::tag_t     result_tag,
  output logic                      result_valid
);

  logic       is_arith;
  logic       is_mul;
  logic [1:0] mul_hist; // bit 0 one cycle ago, bit 1 two cycles ago

  assign is_arith = fu_type == vector_lane_pkg::FU_ARITH;
  assign is_mul   = fu_type == vector_lane_pkg::FU_MUL;

  // arith finishes in 1, mul in 3, so a mul two cycles back lands on the same slot
  assign stall = is_arith & mul_hist[1];

  assign start_arith = is_arith & ~stall;
  assign start_mul   = is_mul;          // multiplies never wait

  // record accepted multiplies
  always_ff @(posedge CLK) begin
    if (reset) begin
      mul_hist <= 2'b00;
    end else begin
      mul_hist <= {mul_hist[0], start_mul};
    end
  end

  // at most one done per cycle, guaranteed by the stall above
  assign result_valid = arith_done | mul_done;

  always_comb begin
    if (arith_done) begin
      result     = arith_result;
      result_tag = arith_tag;
    end else if (mul_done) begin
      result     = mul_result;
      result_tag = mul_tag;
    end else begin
      result     = '0; // quiet bus when idle
      result_tag = '0;
    end
  end

endmodule

//--- rtl/multiply_unit.sv
// three stage pipelined multiplier for one vector lane
// stage one extends the operands, stage two multiplies, stage three picks a half
// takes a new op every cycle, done rises exactly three cycles after start
// ops in flight are independent, each carries its own valid, op and tag

`timescale 1ns/1ps

`include "vector_lane_config.svh"

module multiply_unit (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   start,
  input  vector_lane_pkg::op_t   op,
  input  vector_lane_pkg::word_t src_a,
  input  vector_lane_pkg::word_t src_b,
  input  vector_lane_pkg::tag_t  tag,
  output vector_lane_pkg::word_t result,
  output vector_lane_pkg::tag_t  result_tag,
  output logic                   done
);

  localparam int EXT_W  = `VL_DATA_WIDTH + 1;  // one extra bit for sign or zero fill
  localparam int PROD_W = 2 * `VL_DATA_WIDTH;  // full product kept after stage two

  logic                 sign_ext;               // signed high product needs sign fill
  logic signed [EXT_W-1:0] ext_a, ext_b;
  logic signed [2*EXT_W-1:0] full_prod;

  // stage one, extended operands
  logic                    s1_valid;
  logic signed [EXT_W-1:0] s1_a, s1_b;
  vector_lane_pkg::op_t    s1_op;
  vector_lane_pkg::tag_t   s1_tag;

  // stage two, raw product
  logic                  s2_valid;
  logic [PROD_W-1:0]     s2_prod;
  vector_lane_pkg::op_t  s2_op;
  vector_lane_pkg::tag_t s2_tag;

  assign sign_ext = vector_lane_pkg::mul_op_e'(op) == vector_lane_pkg::MUL_HI_SS;
  assign ext_a    = {sign_ext & src_a[`VL_DATA_WIDTH-1], src_a};
  assign ext_b    = {sign_ext & src_b[`VL_DATA_WIDTH-1], src_b};
  assign full_prod = s1_a * s1_b; // 33x33 signed covers both signed and unsigned

  // valid bits only, the payload just follows them
  always_ff @(posedge CLK) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      s1_valid <= start;
      s2_valid <= s1_valid;
      done     <= s2_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_a    <= ext_a;
    s1_b    <= ext_b;
    s1_op   <= op;
    s1_tag  <= tag;
    s2_prod <= full_prod[PROD_W-1:0]; // top two bits are only sign copies
    s2_op   <= s1_op;
    s2_tag  <= s1_tag;
    result_tag <= s2_tag;
    case (vector_lane_pkg::mul_op_e'(s2_op))
      vector_lane_pkg::MUL_LO:    result <= s2_prod[`VL_DATA_WIDTH-1:0];
      vector_lane_pkg::MUL_HI_SS,
      vector_lane_pkg::MUL_HI_UU: result <= s2_prod[PROD_W-1:`VL_DATA_WIDTH]; // sign from stage one
      default:                    result <= '0; // unknown op
    endcase
  end

endmodule

//--- rtl/arithmetic_unit.sv
// single stage integer alu for one vector lane
// start is a one cycle strobe from the writeback block
// result, result_tag and done come out registered one cycle after start
// unknown opcodes give zero

`timescale 1ns/1ps

`include "vector_lane_config.svh"

module arithmetic_unit (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  start,
  input  vector_lane_pkg::op_t  op,
  input  vector_lane_pkg::word_t src_a,
  input  vector_lane_pkg::word_t src_b,
  input  vector_lane_pkg::tag_t tag,
  output vector_lane_pkg::word_t result,
  output vector_lane_pkg::tag_t result_tag,
  output logic                  done
);

  localparam int SHAMT_W = $clog2(`VL_DATA_WIDTH); // 5 bits for a 32 bit word

  vector_lane_pkg::word_t alu_out; // combinational result of this cycle's op
  logic [SHAMT_W-1:0]     shamt;   // shift amount, upper bits of src_b ignored
  logic                   a_lt_b;  // signed compare for min and max

  assign shamt  = src_b[SHAMT_W-1:0];
  assign a_lt_b = $signed(src_a) < $signed(src_b);

  always_comb begin
    case (vector_lane_pkg::alu_op_e'(op))
      vector_lane_pkg::ALU_ADD: alu_out = src_a + src_b;
      vector_lane_pkg::ALU_SUB: alu_out = src_a - src_b;
      vector_lane_pkg::ALU_AND: alu_out = src_a & src_b;
      vector_lane_pkg::ALU_OR:  alu_out = src_a | src_b;
      vector_lane_pkg::ALU_XOR: alu_out = src_a ^ src_b;
      vector_lane_pkg::ALU_SLL: alu_out = src_a << shamt;
      vector_lane_pkg::ALU_SRL: alu_out = src_a >> shamt;   // zero fill
      vector_lane_pkg::ALU_SRA: alu_out = $signed(src_a) >>> shamt; // sign fill
      vector_lane_pkg::ALU_MIN: alu_out = a_lt_b ? src_a : src_b;
      vector_lane_pkg::ALU_MAX: alu_out = a_lt_b ? src_b : src_a;
      default:                  alu_out = '0; // unknown op
    endcase
  end

  // done follows start by one cycle, payload captured only on start
  always_ff @(posedge CLK) begin
    if (reset) begin
      done       <= 1'b0;
      result     <= '0;
      result_tag <= '0;
    end else begin
      done <= start;
      if (start) begin
        result     <= alu_out;
        result_tag <= tag;
      end
    end
  end

endmodule

//--- rtl/vector_lane_pkg.sv
// shared types for the vector lane
// modules refer to these by scoped name, vector_lane_pkg::word_t etc
// op_t is reinterpreted as alu_op_e or mul_op_e depending on fu_type

`include "vector_lane_config.svh"

package vector_lane_pkg;

  typedef logic [`VL_DATA_WIDTH-1:0] word_t; // one element
  typedef logic [`VL_TAG_WIDTH-1:0]  tag_t;  // element id, returned with result
  typedef logic [`VL_OP_WIDTH-1:0]   op_t;   // raw opcode field

  // which functional unit gets the op
  typedef enum logic [`VL_FU_WIDTH-1:0] {
    FU_NONE  = 2'd0, // idle
    FU_ARITH = 2'd1,
    FU_MUL   = 2'd2
  } fu_type_e;

  // arithmetic unit opcodes
  typedef enum logic [`VL_OP_WIDTH-1:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SLL = 4'h5,
    ALU_SRL = 4'h6,
    ALU_SRA = 4'h7,
    ALU_MIN = 4'h8, // signed
    ALU_MAX = 4'h9  // signed
  } alu_op_e;

  // multiply unit opcodes
  typedef enum logic [`VL_OP_WIDTH-1:0] {
    MUL_LO    = 4'h0, // low half, sign does not matter
    MUL_HI_SS = 4'h1, // high half, signed x signed
    MUL_HI_UU = 4'h2  // high half, unsigned x unsigned
  } mul_op_e;

endpackage

//--- rtl/vector_lane_config.svh
// width settings for the vector lane
// pulled in by the package and by any module that sizes its own vectors
// change the element or tag width here only

`ifndef VECTOR_LANE_CONFIG_SVH
`define VECTOR_LANE_CONFIG_SVH

// one element, rv32 word
`define VL_DATA_WIDTH 32

// element tag, 32 outstanding ids
`define VL_TAG_WIDTH 5

// opcode field shared by both units
`define VL_OP_WIDTH 4

// functional unit selector
`define VL_FU_WIDTH 2

`endif
